// ==== uart_pkg.sv ====
package uart_pkg;

  // FIFO sizing
  localparam int fifo_depth = 8;
  localparam int cnt_width = $clog2(fifo_depth);

  // Default baud setup
  localparam int clock_freq_hz = 10_000_000;
  localparam int baud_default = 115_200;
  localparam logic [15:0] div_reset = 16'(clock_freq_hz / baud_default - 1);

  // Position of the full and empty flags in data register reads
  localparam int flag_bit = 31;

  // Word index, taken from adr[4:2]
  typedef enum logic [2:0] {
    reg_txdata = 3'd0,
    reg_rxdata = 3'd1,
    reg_txctrl = 3'd2,
    reg_rxctrl = 3'd3,
    reg_ie     = 3'd4,
    reg_ip     = 3'd5,
    reg_div    = 3'd6
  } uart_reg_t;

  typedef enum logic [1:0] {
    st_idle,
    st_access,
    st_ack
  } fsm_state_t;

  typedef enum logic [1:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop
  } tx_state_t;

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_t;

endpackage

// ==== uart_fifo.sv ====
`timescale 1ns/1ps

module uart_fifo import uart_pkg::*; (
  input  logic               clock,
  input  logic               reset,
  input  logic               push,
  input  logic [7:0]         push_data,
  input  logic               pop,
  output logic [7:0]         pop_data,
  output logic [cnt_width:0] count,
  output logic               full,
  output logic               empty
);

  logic [7:0]           mem [fifo_depth];
  logic [cnt_width-1:0] wr_ptr;
  logic [cnt_width-1:0] rd_ptr;
  logic                 do_push;
  logic                 do_pop;

  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Depth is a power of two, so the pointers wrap on their own
  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  assign pop_data = mem[rd_ptr];
  assign full     = (count == (cnt_width + 1)'(fifo_depth));
  assign empty    = (count == '0);

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx import uart_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic [15:0] div,
  input  logic        nstop,
  input  logic        valid,
  input  logic [7:0]  data,
  output logic        ready,
  output logic        txd
);

  tx_state_t   state;
  logic [15:0] baud_cnt;
  logic [7:0]  shift;
  logic [2:0]  bit_idx;
  logic        stop_left;

  // Byte is taken only between frames
  assign ready = (state == tx_idle) && valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= tx_idle;
      txd       <= 1'b1;
      bit_idx   <= '0;
      stop_left <= 1'b0;
    end else if (state == tx_idle) begin
      txd <= 1'b1;
      if (valid) begin
        shift     <= data;
        stop_left <= nstop;
        baud_cnt  <= div;
        txd       <= 1'b0;
        state     <= tx_start;
      end
    end else if (baud_cnt != '0) begin
      baud_cnt <= baud_cnt - 1'b1;
    end else begin
      baud_cnt <= div;
      case (state)
        tx_start: begin
          txd     <= shift[0];
          shift   <= shift >> 1;
          bit_idx <= '0;
          state   <= tx_data;
        end
        tx_data: begin
          if (bit_idx == 3'd7) begin
            txd   <= 1'b1;
            state <= tx_stop;
          end else begin
            txd     <= shift[0];
            shift   <= shift >> 1;
            bit_idx <= bit_idx + 1'b1;
          end
        end
        default: begin
          // Second stop bit when nstop was set at accept
          if (stop_left) stop_left <= 1'b0;
          else state <= tx_idle;
        end
      endcase
    end
  end

endmodule

// ==== uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        enable,
  input  logic [15:0] div,
  input  logic        rxd,
  output logic        valid,
  output logic [7:0]  data
);

  rx_state_t   state;
  logic        rxd_meta;
  logic        rxd_sync;
  logic        rxd_prev;
  logic [15:0] baud_cnt;
  logic [2:0]  bit_idx;

  // Two-flop synchronizer plus one stage for edge detection
  always_ff @(posedge clock) begin
    if (reset) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= rx_idle;
      valid   <= 1'b0;
      bit_idx <= '0;
    end else begin
      valid <= 1'b0;
      if (state == rx_idle) begin
        if (enable && rxd_prev && !rxd_sync) begin
          // Wait half a bit to land in the middle of the start bit
          baud_cnt <= div >> 1;
          state    <= rx_start;
        end
      end else if (baud_cnt != '0) begin
        baud_cnt <= baud_cnt - 1'b1;
      end else begin
        baud_cnt <= div;
        case (state)
          rx_start: begin
            bit_idx <= '0;
            // Glitch on the line, not a real start bit
            state   <= rxd_sync ? rx_idle : rx_data;
          end
          rx_data: begin
            data <= {rxd_sync, data[7:1]};
            if (bit_idx == 3'd7) state <= rx_stop;
            else bit_idx <= bit_idx + 1'b1;
          end
          default: begin
            valid <= rxd_sync;
            state <= rx_idle;
          end
        endcase
      end
    end
  end

endmodule

// ==== uart_phy.sv ====
`timescale 1ns/1ps

module uart_phy import uart_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 txen,
  input  logic                 rxen,
  input  logic                 nstop,
  input  logic [15:0]          div,
  input  logic [cnt_width-1:0] txcnt,
  input  logic [cnt_width-1:0] rxcnt,
  input  logic                 tx_push,
  input  logic [7:0]           tx_data,
  input  logic                 rx_pop,
  input  logic                 rxd,
  output logic [7:0]           rx_data,
  output logic                 tx_full,
  output logic                 rx_empty,
  output logic                 tx_below_wm,
  output logic                 rx_above_wm,
  output logic                 txd
);

  logic [cnt_width:0] tx_count;
  logic [cnt_width:0] rx_count;
  logic [7:0]         tx_head;
  logic [7:0]         rx_byte;
  logic               tx_empty;
  logic               tx_ready;
  logic               rx_full;
  logic               rx_valid;

  uart_fifo tx_fifo (
    .clock     (clock),
    .reset     (reset),
    .push      (tx_push),
    .push_data (tx_data),
    .pop       (tx_ready),
    .pop_data  (tx_head),
    .count     (tx_count),
    .full      (tx_full),
    .empty     (tx_empty)
  );

  // Bytes that arrive while the RX FIFO is full are lost
  uart_fifo rx_fifo (
    .clock     (clock),
    .reset     (reset),
    .push      (rx_valid & rxen & ~rx_full),
    .push_data (rx_byte),
    .pop       (rx_pop),
    .pop_data  (rx_data),
    .count     (rx_count),
    .full      (rx_full),
    .empty     (rx_empty)
  );

  uart_tx tx (
    .clock (clock),
    .reset (reset),
    .div   (div),
    .nstop (nstop),
    .valid (txen & ~tx_empty),
    .data  (tx_head),
    .ready (tx_ready),
    .txd   (txd)
  );

  uart_rx rx (
    .clock  (clock),
    .reset  (reset),
    .enable (rxen),
    .div    (div),
    .rxd    (rxd),
    .valid  (rx_valid),
    .data   (rx_byte)
  );

  assign tx_below_wm = (tx_count < {1'b0, txcnt});
  assign rx_above_wm = (rx_count > {1'b0, rxcnt});

endmodule

// ==== uart_bank.sv ====
`timescale 1ns/1ps

module uart_bank import uart_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  uart_reg_t            addr_q,
  input  logic [31:0]          wr_data_q,
  input  logic                 bank_wr_en,
  input  logic                 bank_rd_en,
  input  logic [7:0]           rx_data,
  input  logic                 tx_full,
  input  logic                 rx_empty,
  input  logic                 tx_below_wm,
  input  logic                 rx_above_wm,
  output logic [31:0]          dat_r,
  output logic                 interrupt,
  output logic                 txen,
  output logic                 rxen,
  output logic                 nstop,
  output logic [15:0]          div,
  output logic [cnt_width-1:0] txcnt,
  output logic [cnt_width-1:0] rxcnt
);

  logic [1:0]  ie;
  logic [1:0]  ip;
  logic [31:0] rd_data;

  assign ip = {rx_above_wm, tx_below_wm};

  always_ff @(posedge clock) begin
    if (reset) begin
      txen  <= 1'b0;
      nstop <= 1'b0;
      txcnt <= '0;
      rxen  <= 1'b0;
      rxcnt <= '0;
      ie    <= 2'b00;
      div   <= div_reset;
    end else if (bank_wr_en) begin
      case (addr_q)
        reg_txctrl: begin
          txen  <= wr_data_q[0];
          nstop <= wr_data_q[1];
          txcnt <= wr_data_q[16 +: cnt_width];
        end
        reg_rxctrl: begin
          rxen  <= wr_data_q[0];
          rxcnt <= wr_data_q[16 +: cnt_width];
        end
        reg_ie:  ie  <= wr_data_q[1:0];
        reg_div: div <= wr_data_q[15:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    rd_data = '0;
    case (addr_q)
      reg_txdata: rd_data[flag_bit] = tx_full;
      reg_rxdata: begin
        rd_data[flag_bit] = rx_empty;
        rd_data[7:0]      = rx_data;
      end
      reg_txctrl: begin
        rd_data[0]                = txen;
        rd_data[1]                = nstop;
        rd_data[16 +: cnt_width]  = txcnt;
      end
      reg_rxctrl: begin
        rd_data[0]                = rxen;
        rd_data[16 +: cnt_width]  = rxcnt;
      end
      reg_ie:  rd_data[1:0]  = ie;
      reg_ip:  rd_data[1:0]  = ip;
      reg_div: rd_data[15:0] = div;
      default: ;
    endcase
  end

  // Head of the RX FIFO is sampled here before the pop takes effect
  always_ff @(posedge clock) begin
    if (bank_rd_en) begin
      dat_r <= rd_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      interrupt <= 1'b0;
    end else begin
      interrupt <= |(ie & ip);
    end
  end

endmodule

// ==== uart_fsm.sv ====
`timescale 1ns/1ps

module uart_fsm import uart_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      wr_req,
  input  logic      rd_req,
  input  uart_reg_t addr_q,
  input  logic      tx_full,
  input  logic      rx_empty,
  output logic      busy,
  output logic      ack,
  output logic      bank_wr_en,
  output logic      bank_rd_en,
  output logic      tx_push,
  output logic      rx_pop
);

  fsm_state_t state;
  logic       op_wr;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
      ack   <= 1'b0;
    end else begin
      // ack rises on the edge that ends the access cycle
      ack <= (state == st_access);
      case (state)
        st_idle:   if (wr_req || rd_req) state <= st_access;
        st_access: state <= st_ack;
        default:   state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_idle) begin
      op_wr <= wr_req;
    end
  end

  assign busy = (state != st_idle);

  always_comb begin
    bank_wr_en = 1'b0;
    bank_rd_en = 1'b0;
    tx_push    = 1'b0;
    rx_pop     = 1'b0;
    if (state == st_access) begin
      if (op_wr) begin
        // A write to a full TX FIFO is dropped
        if (addr_q == reg_txdata) tx_push = ~tx_full;
        else bank_wr_en = 1'b1;
      end else begin
        bank_rd_en = 1'b1;
        if (addr_q == reg_rxdata) rx_pop = ~rx_empty;
      end
    end
  end

endmodule

// ==== uart.sv ====
`timescale 1ns/1ps

module uart import uart_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [31:0] adr,
  input  logic [31:0] dat_w,
  output logic [31:0] dat_r,
  output logic        ack,
  input  logic        rxd,
  output logic        txd,
  output logic        interrupt
);

  logic                 wr_req;
  logic                 rd_req;
  logic                 busy;
  uart_reg_t            addr_q;
  logic [31:0]          wr_data_q;
  logic                 bank_wr_en;
  logic                 bank_rd_en;
  logic                 tx_push;
  logic                 rx_pop;
  logic                 txen;
  logic                 rxen;
  logic                 nstop;
  logic [15:0]          div;
  logic [cnt_width-1:0] txcnt;
  logic [cnt_width-1:0] rxcnt;
  logic [7:0]           rx_data;
  logic                 tx_full;
  logic                 rx_empty;
  logic                 tx_below_wm;
  logic                 rx_above_wm;

  assign wr_req = cyc & stb & we;
  assign rd_req = cyc & stb & ~we;

  // Request is held by the master, so capture once while idle
  always_ff @(posedge clock) begin
    if ((wr_req || rd_req) && !busy) begin
      addr_q <= uart_reg_t'(adr[4:2]);
    end
    if (wr_req && !busy) begin
      wr_data_q <= dat_w;
    end
  end

  uart_fsm fsm (
    .clock      (clock),
    .reset      (reset),
    .wr_req     (wr_req),
    .rd_req     (rd_req),
    .addr_q     (addr_q),
    .tx_full    (tx_full),
    .rx_empty   (rx_empty),
    .busy       (busy),
    .ack        (ack),
    .bank_wr_en (bank_wr_en),
    .bank_rd_en (bank_rd_en),
    .tx_push    (tx_push),
    .rx_pop     (rx_pop)
  );

  uart_bank bank (
    .clock       (clock),
    .reset       (reset),
    .addr_q      (addr_q),
    .wr_data_q   (wr_data_q),
    .bank_wr_en  (bank_wr_en),
    .bank_rd_en  (bank_rd_en),
    .rx_data     (rx_data),
    .tx_full     (tx_full),
    .rx_empty    (rx_empty),
    .tx_below_wm (tx_below_wm),
    .rx_above_wm (rx_above_wm),
    .dat_r       (dat_r),
    .interrupt   (interrupt),
    .txen        (txen),
    .rxen        (rxen),
    .nstop       (nstop),
    .div         (div),
    .txcnt       (txcnt),
    .rxcnt       (rxcnt)
  );

  uart_phy phy (
    .clock       (clock),
    .reset       (reset),
    .txen        (txen),
    .rxen        (rxen),
    .nstop       (nstop),
    .div         (div),
    .txcnt       (txcnt),
    .rxcnt       (rxcnt),
    .tx_push     (tx_push),
    .tx_data     (wr_data_q[7:0]),
    .rx_pop      (rx_pop),
    .rxd         (rxd),
    .rx_data     (rx_data),
    .tx_full     (tx_full),
    .rx_empty    (rx_empty),
    .tx_below_wm (tx_below_wm),
    .rx_above_wm (rx_above_wm),
    .txd         (txd)
  );

endmodule

// ==== uart_checker.sv ====
`timescale 1ns/1ps

module uart_checker (
  input logic clock,
  input logic reset,
  input logic cyc,
  input logic stb,
  input logic ack,
  input logic txd,
  input logic txen
);

  int fail_count = 0;

  // ack is a single-cycle pulse
  ack_single_pulse: assert property (@(posedge clock) disable iff (reset) ack |=> !ack)
    else begin
      $error("ack stayed high for more than one cycle");
      fail_count++;
    end

  ack_inside_cycle: assert property (@(posedge clock) disable iff (reset) ack |-> (cyc && stb))
    else begin
      $error("ack high outside of a bus cycle");
      fail_count++;
    end

  // Idle line while the transmitter is off
  line_idle_when_off: assert property (@(posedge clock) disable iff (reset) !txen |-> txd)
    else begin
      $error("txd low while txen is clear");
      fail_count++;
    end

endmodule

bind uart uart_checker chk (
  .clock (clock),
  .reset (reset),
  .cyc   (cyc),
  .stb   (stb),
  .ack   (ack),
  .txd   (txd),
  .txen  (txen)
);

// ==== tb_uart.sv ====
`timescale 1ns/1ps

module tb_uart import uart_pkg::*; ();

  localparam int test_div = 3;
  localparam int bit_cycles = test_div + 1;
  // Frames sent over the whole run: 6 + 8 + 4 + 4
  localparam int frame_count = 22;
  localparam int watchdog_ns = frame_count * 11 * bit_cycles * 20 + 100_000;
  // 10 MHz over 115200 baud is 86 cycles per bit, less one
  localparam logic [31:0] expected_div_reset = 32'd85;

  logic        clock;
  logic        reset;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [31:0] adr;
  logic [31:0] dat_w;
  logic [31:0] dat_r;
  logic        ack;
  logic        line;
  logic        interrupt;
  logic [31:0] rng_state;

  // Serial loopback, txd drives rxd
  uart dut (
    .clock     (clock),
    .reset     (reset),
    .cyc       (cyc),
    .stb       (stb),
    .we        (we),
    .adr       (adr),
    .dat_w     (dat_w),
    .dat_r     (dat_r),
    .ack       (ack),
    .rxd       (line),
    .txd       (line),
    .interrupt (interrupt)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic expect_equal(input string test, input logic [31:0] expected,
                              input logic [31:0] actual);
    assert (actual === expected)
      else abort_run($sformatf("[ERROR] %s: expected %h, actual %h", test, expected, actual));
  endtask

  task automatic expect_within(input string test, input int lo, input int hi, input int actual);
    assert (actual >= lo && actual <= hi)
      else abort_run($sformatf("[ERROR] %s: expected %0d to %0d, actual %0d",
                               test, lo, hi, actual));
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_random(output logic [31:0] value);
    rng_state = xorshift32(rng_state);
    value = rng_state;
  endtask

  task automatic bus_cycle(input logic write, input uart_reg_t reg_idx,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    int edges;
    edges = 0;
    @(posedge clock);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= write;
    adr   <= {27'd0, reg_idx, 2'b00};
    dat_w <= wdata;
    do begin
      @(posedge clock);
      @(negedge clock);
      edges++;
    end while (!ack && edges < 16);
    assert (ack) else abort_run("Bus access was never acknowledged");
    expect_equal("ack latency", 32'd2, edges);
    rdata = dat_r;
    @(posedge clock);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic wb_write(input uart_reg_t reg_idx, input logic [31:0] wdata);
    logic [31:0] unused;
    bus_cycle(1'b1, reg_idx, wdata, unused);
  endtask

  task automatic wb_read(input uart_reg_t reg_idx, output logic [31:0] rdata);
    bus_cycle(1'b0, reg_idx, 32'd0, rdata);
  endtask

  // Polls rxdata until a byte shows up
  task automatic receive_byte(input string test, input logic [7:0] expected);
    logic [31:0] value;
    int polls;
    polls = 0;
    do begin
      wb_read(reg_rxdata, value);
      polls++;
    end while (value[flag_bit] && polls < 500);
    assert (!value[flag_bit]) else abort_run({test, ": no byte arrived at the receiver"});
    expect_equal(test, {24'd0, expected}, value);
  endtask

  // Line high for longer than any frame can hold it
  task automatic wait_line_idle();
    int high_run;
    int waited;
    high_run = 0;
    waited = 0;
    while (high_run < 12 * bit_cycles && waited < 4000) begin
      @(negedge clock);
      waited++;
      high_run = line ? high_run + 1 : 0;
    end
    assert (high_run >= 12 * bit_cycles) else abort_run("Serial line never went idle");
  endtask

  task automatic measure_stop_gap(output int gap);
    int waited;
    waited = 0;
    gap = 0;
    while (line && waited < 2000) begin
      @(negedge clock);
      waited++;
    end
    // Start bit and zero data bits, then the stop bits
    while (!line && waited < 2000) begin
      @(negedge clock);
      waited++;
    end
    while (line && waited < 2000) begin
      @(negedge clock);
      waited++;
      gap++;
    end
    assert (waited < 2000) else abort_run("Stop bit measurement timed out");
  endtask

  task automatic reset_and_registers();
    uart_reg_t   regs  [4] = '{reg_div, reg_txctrl, reg_rxctrl, reg_ie};
    logic [31:0] masks [4] = '{32'h0000_ffff, 32'h0007_0003, 32'h0007_0001, 32'h0000_0003};
    logic [31:0] value;
    logic [31:0] rnd;
    wb_read(reg_div, value);
    expect_equal("reset div", expected_div_reset, value);
    for (int i = 1; i < 4; i++) begin
      wb_read(regs[i], value);
      expect_equal($sformatf("reset %s", regs[i].name()), 32'd0, value);
    end
    // Only the defined fields survive a random write
    for (int i = 0; i < 4; i++) begin
      next_random(rnd);
      wb_write(regs[i], rnd);
      wb_read(regs[i], value);
      expect_equal($sformatf("readback %s", regs[i].name()), rnd & masks[i], value);
    end
    wb_write(reg_txctrl, 32'd0);
    wb_write(reg_rxctrl, 32'd0);
    wb_write(reg_ie, 32'd0);
  endtask

  task automatic loopback_random_bytes();
    logic [7:0]  sent [6];
    logic [31:0] value;
    wb_write(reg_div, test_div);
    wb_write(reg_rxctrl, 32'h1);
    wb_write(reg_txctrl, 32'h1);
    foreach (sent[i]) begin
      next_random(value);
      sent[i] = value[7:0];
      wb_write(reg_txdata, {24'd0, sent[i]});
    end
    foreach (sent[i]) receive_byte("loopback byte", sent[i]);
    wb_read(reg_rxdata, value);
    expect_equal("loopback empty flag", 32'd1, value[flag_bit]);
    wait_line_idle();
  endtask

  task automatic full_flag_discard();
    logic [7:0]  sent [8];
    logic [31:0] value;
    wb_write(reg_txctrl, 32'h0);
    foreach (sent[i]) begin
      next_random(value);
      sent[i] = value[7:0];
      wb_write(reg_txdata, {24'd0, sent[i]});
    end
    wb_read(reg_txdata, value);
    expect_equal("txdata full flag", 32'h8000_0000, value);
    wb_write(reg_txdata, 32'h0000_00a5);
    wb_write(reg_txctrl, 32'h1);
    foreach (sent[i]) receive_byte("full fifo byte", sent[i]);
    wait_line_idle();
    wb_read(reg_rxdata, value);
    expect_equal("ninth byte discarded", 32'd1, value[flag_bit]);
  endtask

  task automatic watermark_interrupts();
    logic [31:0] value;
    logic [7:0]  rx_byte;
    int polls;
    // TX side, txcnt 1 with the transmitter held off
    wb_write(reg_rxctrl, 32'h0);
    wb_write(reg_txctrl, 32'h0001_0000);
    wb_write(reg_ie, 32'h1);
    @(negedge clock);
    expect_equal("txwm empty interrupt", 32'd1, interrupt);
    wb_read(reg_ip, value);
    expect_equal("txwm empty ip", 32'h1, value);
    for (int i = 0; i < 3; i++) begin
      wb_write(reg_txdata, 32'h0000_0050 + i);
      @(negedge clock);
      expect_equal("txwm filled interrupt", 32'd0, interrupt);
    end
    wb_read(reg_ip, value);
    expect_equal("txwm filled ip", 32'h0, value);
    wb_write(reg_txctrl, 32'h0001_0001);
    polls = 0;
    do begin
      wb_read(reg_ip, value);
      polls++;
    end while (!value[0] && polls < 500);
    expect_equal("txwm drained ip", 32'h1, value);
    @(negedge clock);
    expect_equal("txwm drained interrupt", 32'd1, interrupt);
    wait_line_idle();
    // RX side, rxcnt 0 and txcnt 0
    wb_write(reg_txctrl, 32'h1);
    wb_write(reg_rxctrl, 32'h1);
    wb_write(reg_ie, 32'h2);
    @(negedge clock);
    expect_equal("rxwm idle interrupt", 32'd0, interrupt);
    next_random(value);
    rx_byte = value[7:0];
    wb_write(reg_txdata, {24'd0, rx_byte});
    polls = 0;
    do begin
      wb_read(reg_ip, value);
      polls++;
    end while (!value[1] && polls < 500);
    expect_equal("rxwm ip", 32'h2, value);
    @(negedge clock);
    expect_equal("rxwm raised interrupt", 32'd1, interrupt);
    wb_read(reg_rxdata, value);
    expect_equal("rxwm byte", {24'd0, rx_byte}, value);
    @(negedge clock);
    expect_equal("rxwm cleared interrupt", 32'd0, interrupt);
    wb_read(reg_ip, value);
    expect_equal("rxwm cleared ip", 32'h0, value);
    wait_line_idle();
    wb_write(reg_ie, 32'h0);
  endtask

  task automatic stop_bit_spacing();
    int gap;
    wb_write(reg_rxctrl, 32'h0);
    for (int stops = 2; stops >= 1; stops--) begin
      wb_write(reg_txctrl, (stops == 2) ? 32'h2 : 32'h0);
      wb_write(reg_txdata, 32'h0);
      wb_write(reg_txdata, 32'h0);
      wb_write(reg_txctrl, (stops == 2) ? 32'h3 : 32'h1);
      measure_stop_gap(gap);
      expect_within($sformatf("gap with %0d stop bits", stops),
                    stops * bit_cycles, (stops + 1) * bit_cycles - 1, gap);
      wait_line_idle();
    end
    wb_write(reg_txctrl, 32'h0);
  endtask

  initial begin
    #(watchdog_ns);
    abort_run("Watchdog expired before the tests finished");
  end

  // Stop at the first failure of a bound assertion
  initial begin
    wait (dut.chk.fail_count != 0);
    abort_run("A bound assertion on the bus or the serial line failed");
  end

  initial begin
    reset     = 1'b1;
    cyc       = 1'b0;
    stb       = 1'b0;
    we        = 1'b0;
    adr       = '0;
    dat_w     = '0;
    rng_state = 32'd99228;
    repeat (4) @(posedge clock);
    reset <= 1'b0;
    reset_and_registers();
    loopback_random_bytes();
    full_flag_discard();
    watermark_interrupts();
    stop_bit_spacing();
    if (dut.chk.fail_count == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      abort_run("Bound assertions on the bus or the serial line failed");
    end
  end

endmodule

// ==== all.f ====
uart_pkg.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
uart_phy.sv
uart_bank.sv
uart_fsm.sv
uart.sv
uart_checker.sv
tb_uart.sv
